// ==== soc_pkg.sv ====
/* SoC shared definitions
   Bus widths, address map and interrupt types for the system bus */
`default_nettype none

package soc_pkg;

  // Word address, byte bit 0 is carried by the selects
  typedef logic [19:1] addr_t;
  typedef logic [15:0] data_t;
  typedef logic [1:0]  sel_t;

  typedef logic [7:0]  irq_vec_t;
  typedef logic [2:0]  iid_t;

  // 10 red plus 4 green
  typedef logic [13:0] led_t;
  typedef logic [9:0]  sw_t;

  // I/O port window 0xF100 to 0xF103, two words
  localparam addr_t GPIO_IO_BASE = addr_t'(20'hF100 >> 1);
  // Only the 16-bit I/O space is compared, low word bit ignored
  localparam addr_t GPIO_IO_MASK = 19'h07FFE;

  // Vector handed out during interrupt acknowledge
  localparam data_t INT_VECTOR_BASE = 16'd8;

  // Unmapped reads float high
  localparam data_t DEFAULT_READ_DATA = 16'hFFFF;

endpackage

`default_nettype wire

// ==== soc_timer.sv ====
/* Periodic timer, one tick per period on interrupt line 0 */
`timescale 1ns/1ps
`default_nettype none

module soc_timer #(
  parameter int TIMER_PERIOD = 1000
) (
  input  logic clk,
  input  logic rst_lck,
  output logic tick_o
);

  localparam int CNT_W = (TIMER_PERIOD > 1) ? $clog2(TIMER_PERIOD) : 1;

  logic [CNT_W-1:0] count;
  logic             wrap;

  assign wrap = (count == CNT_W'(TIMER_PERIOD - 1));

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      count  <= '0;
      tick_o <= 1'b0;
    end else begin
      count  <= wrap ? '0 : count + 1'b1;
      tick_o <= wrap;
    end
  end

endmodule

`default_nettype wire

// ==== soc_pic.sv ====
/* Simple priority interrupt controller
   Edge-latched requests, lowest line wins, cleared on acknowledge */
`timescale 1ns/1ps
`default_nettype none

module soc_pic (
  input  logic              clk,
  input  logic              rst_lck,
  input  soc_pkg::irq_vec_t irq_i,
  input  logic              inta_i,
  output logic              intr_o,
  output soc_pkg::iid_t     iid_o
);

  soc_pkg::irq_vec_t irq_q;
  soc_pkg::irq_vec_t pending;
  soc_pkg::irq_vec_t rise;
  soc_pkg::irq_vec_t clr;
  soc_pkg::iid_t     lowest;
  logic              inta_q;

  assign rise = irq_i & ~irq_q;

  // Only the first acknowledge cycle retires the line
  assign clr = (inta_i & ~inta_q) ? (soc_pkg::irq_vec_t'(1) << iid_o) : '0;

  always_comb begin
    lowest = '0;
    for (int i = 7; i >= 0; i--) begin
      if (pending[i]) lowest = soc_pkg::iid_t'(i);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      irq_q   <= '0;
      inta_q  <= 1'b0;
      pending <= '0;
      iid_o   <= '0;
    end else begin
      irq_q   <= irq_i;
      inta_q  <= inta_i;
      // A fresh edge beats a clear on the same line
      pending <= (pending & ~clr) | rise;
      iid_o   <= lowest;
    end
  end

  assign intr_o = |pending;

endmodule

`default_nettype wire

// ==== soc_gpio.sv ====
/* Switch and LED port
   Word 0 reads the switches, word 1 holds the LED register */
`timescale 1ns/1ps
`default_nettype none

module soc_gpio (
  input  logic           clk,
  input  logic           rst_lck,
  input  logic           stb_i,
  input  logic           we_i,
  input  soc_pkg::sel_t  sel_i,
  input  soc_pkg::addr_t adr_i,
  input  soc_pkg::data_t dat_i,
  output soc_pkg::data_t dat_o,
  output logic           ack_o,
  input  soc_pkg::sw_t   sw_i,
  output soc_pkg::led_t  led_o
);

  soc_pkg::led_t led_q;
  logic          wr_led;

  // Low word bit picks the register
  assign wr_led = stb_i & we_i & ~ack_o & adr_i[1];

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      ack_o <= 1'b0;
      led_q <= '0;
    end else begin
      ack_o <= stb_i & ~ack_o;
      if (wr_led && sel_i[0]) led_q[7:0]  <= dat_i[7:0];
      if (wr_led && sel_i[1]) led_q[13:8] <= dat_i[13:8];
    end
  end

  // Read data captured with the ack
  always_ff @(posedge clk) begin
    if (stb_i) begin
      dat_o <= adr_i[1] ? soc_pkg::data_t'(led_q) : soc_pkg::data_t'(sw_i);
    end
  end

  assign led_o = led_q;

endmodule

`default_nettype wire

// ==== soc_scratch_ram.sv ====
/* Scratch word memory
   Byte-writable on-chip RAM with one wait state */
`timescale 1ns/1ps
`default_nettype none

module soc_scratch_ram #(
  parameter int RAM_ADDR_BITS = 10
) (
  input  logic           clk,
  input  logic           rst_lck,
  input  logic           stb_i,
  input  logic           we_i,
  input  soc_pkg::sel_t  sel_i,
  input  soc_pkg::addr_t adr_i,
  input  soc_pkg::data_t dat_i,
  output soc_pkg::data_t dat_o,
  output logic           ack_o
);

  soc_pkg::data_t mem [2**RAM_ADDR_BITS];

  logic [RAM_ADDR_BITS-1:0] idx;
  logic                     wr;

  assign idx = adr_i[RAM_ADDR_BITS:1];
  assign wr  = stb_i & we_i & ~ack_o;

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= stb_i & ~ack_o;
    end
  end

  // Lane writes and registered read
  always_ff @(posedge clk) begin
    if (wr && sel_i[0]) mem[idx][7:0]  <= dat_i[7:0];
    if (wr && sel_i[1]) mem[idx][15:8] <= dat_i[15:8];
    if (stb_i) dat_o <= mem[idx];
  end

endmodule

`default_nettype wire

// ==== soc_bus_ctrl.sv ====
/* System bus controller
   Address decode, default responder and read-data/vector return path */
`timescale 1ns/1ps
`default_nettype none

module soc_bus_ctrl #(
  parameter int RAM_ADDR_BITS = 10
) (
  input  logic           clk,
  input  logic           rst_lck,
  input  logic           wb_cyc_i,
  input  logic           wb_stb_i,
  input  logic           wb_we_i,
  input  logic           wb_tga_i,
  input  soc_pkg::addr_t wb_adr_i,
  input  soc_pkg::sel_t  wb_sel_i,
  input  soc_pkg::data_t wb_dat_i,
  output soc_pkg::data_t wb_dat_o,
  output logic           wb_ack_o,
  input  logic           inta_i,
  input  soc_pkg::iid_t  iid_i,
  output logic           gpio_stb_o,
  output logic           ram_stb_o,
  output logic           slv_we_o,
  output soc_pkg::sel_t  slv_sel_o,
  output soc_pkg::addr_t slv_adr_o,
  output soc_pkg::data_t slv_dat_o,
  input  logic           gpio_ack_i,
  input  soc_pkg::data_t gpio_dat_i,
  input  logic           ram_ack_i,
  input  soc_pkg::data_t ram_dat_i
);

  logic req;
  logic io_hit;
  logic ram_hit;
  logic def_stb;
  logic def_ack;

  assign req = wb_cyc_i & wb_stb_i;

  // Tag set selects I/O space
  assign io_hit = wb_tga_i &
                  ((wb_adr_i & soc_pkg::GPIO_IO_MASK) ==
                   (soc_pkg::GPIO_IO_BASE & soc_pkg::GPIO_IO_MASK));
  // RAM sits at the bottom of memory space
  assign ram_hit = ~wb_tga_i & ((wb_adr_i >> RAM_ADDR_BITS) == '0);

  assign gpio_stb_o = req & io_hit;
  assign ram_stb_o  = req & ram_hit;
  assign def_stb    = req & ~io_hit & ~ram_hit;

  // Shared slave-side request fields
  assign slv_we_o  = wb_we_i;
  assign slv_sel_o = wb_sel_i;
  assign slv_adr_o = wb_adr_i;
  assign slv_dat_o = wb_dat_i;

  // Default responder, one wait state like the real slaves
  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      def_ack <= 1'b0;
    end else begin
      def_ack <= def_stb & ~def_ack;
    end
  end

  assign wb_ack_o = gpio_ack_i | ram_ack_i | def_ack;

  // Vector overrides read data during acknowledge
  always_comb begin
    if (inta_i) begin
      wb_dat_o = soc_pkg::INT_VECTOR_BASE + soc_pkg::data_t'(iid_i);
    end else if (gpio_ack_i) begin
      wb_dat_o = gpio_dat_i;
    end else if (ram_ack_i) begin
      wb_dat_o = ram_dat_i;
    end else begin
      wb_dat_o = soc_pkg::DEFAULT_READ_DATA;
    end
  end

endmodule

`default_nettype wire

// ==== soc_top.sv ====
/* PC SoC system bus top
   Bus controller with GPIO, scratch RAM, timer and PIC around it */
`timescale 1ns/1ps
`default_nettype none

module soc_top #(
  parameter int RAM_ADDR_BITS = 10,
  parameter int TIMER_PERIOD  = 1000
) (
  input  logic           clk,
  input  logic           rst_lck,
  input  logic           wb_cyc_i,
  input  logic           wb_stb_i,
  input  logic           wb_we_i,
  input  logic           wb_tga_i,
  input  soc_pkg::addr_t wb_adr_i,
  input  soc_pkg::sel_t  wb_sel_i,
  input  soc_pkg::data_t wb_dat_i,
  output soc_pkg::data_t wb_dat_o,
  output logic           wb_ack_o,
  input  soc_pkg::sw_t   sw_i,
  input  logic [7:1]     irq_i,
  output soc_pkg::led_t  led_o,
  output logic           intr_o,
  input  logic           inta_i
);

  logic           gpio_stb;
  logic           ram_stb;
  logic           slv_we;
  soc_pkg::sel_t  slv_sel;
  soc_pkg::addr_t slv_adr;
  soc_pkg::data_t slv_dat;
  logic           gpio_ack;
  soc_pkg::data_t gpio_dat;
  logic           ram_ack;
  soc_pkg::data_t ram_dat;
  logic           timer_tick;
  soc_pkg::iid_t  iid;

  soc_bus_ctrl #(.RAM_ADDR_BITS(RAM_ADDR_BITS)) u_bus_ctrl (
    .clk        (clk),
    .rst_lck    (rst_lck),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_we_i    (wb_we_i),
    .wb_tga_i   (wb_tga_i),
    .wb_adr_i   (wb_adr_i),
    .wb_sel_i   (wb_sel_i),
    .wb_dat_i   (wb_dat_i),
    .wb_dat_o   (wb_dat_o),
    .wb_ack_o   (wb_ack_o),
    .inta_i     (inta_i),
    .iid_i      (iid),
    .gpio_stb_o (gpio_stb),
    .ram_stb_o  (ram_stb),
    .slv_we_o   (slv_we),
    .slv_sel_o  (slv_sel),
    .slv_adr_o  (slv_adr),
    .slv_dat_o  (slv_dat),
    .gpio_ack_i (gpio_ack),
    .gpio_dat_i (gpio_dat),
    .ram_ack_i  (ram_ack),
    .ram_dat_i  (ram_dat)
  );

  soc_gpio u_gpio (
    .clk     (clk),
    .rst_lck (rst_lck),
    .stb_i   (gpio_stb),
    .we_i    (slv_we),
    .sel_i   (slv_sel),
    .adr_i   (slv_adr),
    .dat_i   (slv_dat),
    .dat_o   (gpio_dat),
    .ack_o   (gpio_ack),
    .sw_i    (sw_i),
    .led_o   (led_o)
  );

  soc_scratch_ram #(.RAM_ADDR_BITS(RAM_ADDR_BITS)) u_ram (
    .clk     (clk),
    .rst_lck (rst_lck),
    .stb_i   (ram_stb),
    .we_i    (slv_we),
    .sel_i   (slv_sel),
    .adr_i   (slv_adr),
    .dat_i   (slv_dat),
    .dat_o   (ram_dat),
    .ack_o   (ram_ack)
  );

  soc_timer #(.TIMER_PERIOD(TIMER_PERIOD)) u_timer (
    .clk     (clk),
    .rst_lck (rst_lck),
    .tick_o  (timer_tick)
  );

  // Timer owns line 0, outside requests fill 7..1
  soc_pic u_pic (
    .clk     (clk),
    .rst_lck (rst_lck),
    .irq_i   ({irq_i, timer_tick}),
    .inta_i  (inta_i),
    .intr_o  (intr_o),
    .iid_o   (iid)
  );

endmodule

`default_nettype wire

// ==== tb_soc_clk.sv ====
/* Testbench clock and reset source
   Free-running clock, synchronous reset held low for a fixed count */
`timescale 1ns/1ps
`default_nettype none

module tb_soc_clk #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_lck_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Released on a falling edge like every other input
  initial begin
    rst_lck_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_lck_o = 1'b1;
  end

endmodule

`default_nettype wire

// ==== tb_soc_checker.sv ====
/* Wishbone handshake and interrupt reset assertions
   Bound into the SoC top level */
`timescale 1ns/1ps
`default_nettype none

module tb_soc_checker (
  input logic clk,
  input logic rst_lck,
  input logic wb_cyc_i,
  input logic wb_stb_i,
  input logic wb_ack_o,
  input logic intr_o
);

  int   fail_count = 0;
  logic req;

  assign req = wb_cyc_i & wb_stb_i;

  // Slaves only answer inside a live request
  ack_needs_req: assert property (@(posedge clk) disable iff (!rst_lck)
    wb_ack_o |-> req)
    else begin
      $error("ack high without cyc and stb");
      fail_count++;
    end

  ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_lck)
    wb_ack_o |=> !wb_ack_o)
    else begin
      $error("ack held longer than one cycle");
      fail_count++;
    end

  ack_after_req: assert property (@(posedge clk) disable iff (!rst_lck)
    $rose(req) |=> wb_ack_o)
    else begin
      $error("ack missing one cycle after a new request");
      fail_count++;
    end

  intr_in_reset: assert property (@(posedge clk) !rst_lck |=> !intr_o)
    else begin
      $error("intr_o high during reset");
      fail_count++;
    end

endmodule

bind soc_top tb_soc_checker u_checker (
  .clk      (clk),
  .rst_lck  (rst_lck),
  .wb_cyc_i (wb_cyc_i),
  .wb_stb_i (wb_stb_i),
  .wb_ack_o (wb_ack_o),
  .intr_o   (intr_o)
);

`default_nettype wire

// ==== tb_soc.sv ====
/* System bus testbench
   Random Wishbone traffic and interrupt checks against a reference model */
`timescale 1ns/1ps
`default_nettype none

module tb_soc;

  localparam int CLK_PERIOD   = 20;
  localparam int TIMER_PERIOD = 200;
  localparam int RAM_WORDS    = 1024;
  localparam int WORK_WORDS   = 16;
  localparam int MEM_OPS      = 200;
  localparam int IO_OPS       = 20;
  localparam int UNMAP_OPS    = 20;
  localparam int PRIO_ROUNDS  = 8;
  localparam int ACCESS_TOTAL = WORK_WORDS + 2 * MEM_OPS + 4 * IO_OPS +
                                4 * UNMAP_OPS + WORK_WORDS + 9 * PRIO_ROUNDS + 2;
  // Twenty cycles per access, plus room for the timer test
  localparam int WATCHDOG_CYCLES = ACCESS_TOTAL * 20 + 3 * (TIMER_PERIOD + 10) + 200;

  // Byte addresses 0xF100 and 0xF102 as word addresses
  localparam soc_pkg::addr_t SW_ADR  = 19'h07880;
  localparam soc_pkg::addr_t LED_ADR = 19'h07881;

  logic           clk;
  logic           rst_lck;
  logic           wb_cyc;
  logic           wb_stb;
  logic           wb_we;
  logic           wb_tga;
  soc_pkg::addr_t wb_adr;
  soc_pkg::sel_t  wb_sel;
  soc_pkg::data_t wb_wdat;
  soc_pkg::data_t wb_rdat;
  logic           wb_ack;
  soc_pkg::sw_t   sw;
  logic [7:1]     irq_lines;
  soc_pkg::led_t  led;
  logic           intr;
  logic           inta;

  // Reference model state
  soc_pkg::data_t    m_ram [RAM_WORDS];
  soc_pkg::led_t     m_led;
  soc_pkg::irq_vec_t m_pend;
  soc_pkg::irq_vec_t m_irq_q;
  soc_pkg::iid_t     m_iid;
  logic              m_inta_q;
  logic              m_tick;
  int                m_cycles;

  int work_idx [WORK_WORDS];
  int pass_cnt;
  int fail_cnt;

  tb_soc_clk #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(8)) u_clk (
    .clk_o     (clk),
    .rst_lck_o (rst_lck)
  );

  soc_top #(.RAM_ADDR_BITS(10), .TIMER_PERIOD(TIMER_PERIOD)) DUT (
    .clk      (clk),
    .rst_lck  (rst_lck),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_tga_i (wb_tga),
    .wb_adr_i (wb_adr),
    .wb_sel_i (wb_sel),
    .wb_dat_i (wb_wdat),
    .wb_dat_o (wb_rdat),
    .wb_ack_o (wb_ack),
    .sw_i     (sw),
    .irq_i    (irq_lines),
    .led_o    (led),
    .intr_o   (intr),
    .inta_i   (inta)
  );

  function automatic soc_pkg::iid_t lowest_pending(input soc_pkg::irq_vec_t p);
    for (int i = 0; i < 8; i++) begin
      if (p[i]) return soc_pkg::iid_t'(i);
    end
    return '0;
  endfunction

  function automatic soc_pkg::data_t merge_lanes(input soc_pkg::data_t old_v,
                                                 input soc_pkg::data_t new_v,
                                                 input soc_pkg::sel_t s);
    soc_pkg::data_t r;
    r = old_v;
    if (s[0]) r[7:0] = new_v[7:0];
    if (s[1]) r[15:8] = new_v[15:8];
    return r;
  endfunction

  // Timer ticks every period after release, PIC latches rising edges
  always @(posedge clk) begin : pic_model
    soc_pkg::irq_vec_t req;
    soc_pkg::irq_vec_t clr;
    soc_pkg::iid_t     low;
    if (!rst_lck) begin
      m_pend   = '0;
      m_irq_q  = '0;
      m_iid    = '0;
      m_inta_q = 1'b0;
      m_tick   = 1'b0;
      m_cycles = 0;
    end else begin
      req = {irq_lines, m_tick};
      clr = (inta && !m_inta_q) ? (soc_pkg::irq_vec_t'(1) << m_iid) : '0;
      low = lowest_pending(m_pend);
      m_pend   = (m_pend & ~clr) | (req & ~m_irq_q);
      m_iid    = low;
      m_irq_q  = req;
      m_inta_q = inta;
      m_cycles++;
      m_tick   = (m_cycles % TIMER_PERIOD) == 0;
    end
  end

  task automatic report_error(input string msg);
    fail_cnt++;
    $display("error at %0t: %s", $time, msg);
  endtask

  task automatic note_result(input logic ok, input string name,
                             input logic [15:0] exp_v, input logic [15:0] act_v);
    if (ok) begin
      pass_cnt++;
    end else begin
      fail_cnt++;
      $display("mismatch at %0t: %s expected %h, got %h", $time, name, exp_v, act_v);
    end
  endtask

  task automatic check_data(input string name, input soc_pkg::data_t exp_v,
                            input soc_pkg::data_t act_v);
    note_result(act_v === exp_v, name, exp_v, act_v);
  endtask

  task automatic check_led(input string name, input soc_pkg::led_t exp_v,
                           input soc_pkg::led_t act_v);
    note_result(act_v === exp_v, name, 16'(exp_v), 16'(act_v));
  endtask

  task automatic check_iid(input string name, input soc_pkg::iid_t exp_v,
                           input soc_pkg::iid_t act_v);
    note_result(act_v === exp_v, name, 16'(exp_v), 16'(act_v));
  endtask

  task automatic check_flag(input string name, input logic exp_v, input logic act_v);
    note_result(act_v === exp_v, name, 16'(exp_v), 16'(act_v));
  endtask

  task automatic bus_access(input logic wr, input logic io, input soc_pkg::addr_t a,
                            input soc_pkg::sel_t s, input soc_pkg::data_t d,
                            output soc_pkg::data_t q);
    int waited;
    @(negedge clk);
    wb_cyc  = 1'b1;
    wb_stb  = 1'b1;
    wb_we   = wr;
    wb_tga  = io;
    wb_adr  = a;
    wb_sel  = s;
    wb_wdat = d;
    waited  = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!wb_ack && waited < 20);
    q = wb_rdat;
    if (!wb_ack) begin
      report_error($sformatf("no acknowledge within %0d cycles for address %h", waited, a));
    end else if (waited != 1) begin
      report_error($sformatf("acknowledge after %0d cycles instead of 1", waited));
    end
    // Request stays up through the edge that samples ack
    @(negedge clk);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic bus_write(input logic io, input soc_pkg::addr_t a,
                           input soc_pkg::sel_t s, input soc_pkg::data_t d);
    soc_pkg::data_t unused_q;
    bus_access(1'b1, io, a, s, d, unused_q);
  endtask

  task automatic bus_read(input logic io, input soc_pkg::addr_t a, output soc_pkg::data_t q);
    bus_access(1'b0, io, a, 2'b11, '0, q);
  endtask

  task automatic int_ack(output soc_pkg::data_t vec);
    @(negedge clk);
    inta = 1'b1;
    @(negedge clk);
    vec  = wb_rdat;
    inta = 1'b0;
    // iid settles one cycle after the pending bit clears
    repeat (2) @(negedge clk);
  endtask

  task automatic end_test(input string name, input int errs_before);
    $display("test %s done, %0d failed checks", name, fail_cnt - errs_before);
  endtask

  task automatic test_memory();
    soc_pkg::sel_t  s;
    soc_pkg::data_t d;
    soc_pkg::data_t q;
    int             k;
    int             errs;
    errs = fail_cnt;
    for (int i = 0; i < WORK_WORDS; i++) begin
      work_idx[i] = $urandom_range(0, RAM_WORDS - 1);
      d = soc_pkg::data_t'($urandom);
      bus_write(1'b0, soc_pkg::addr_t'(work_idx[i]), 2'b11, d);
      m_ram[work_idx[i]] = d;
    end
    for (int n = 0; n < MEM_OPS; n++) begin
      k = $urandom_range(0, WORK_WORDS - 1);
      s = soc_pkg::sel_t'($urandom);
      d = soc_pkg::data_t'($urandom);
      bus_write(1'b0, soc_pkg::addr_t'(work_idx[k]), s, d);
      m_ram[work_idx[k]] = merge_lanes(m_ram[work_idx[k]], d, s);
      k = $urandom_range(0, WORK_WORDS - 1);
      bus_read(1'b0, soc_pkg::addr_t'(work_idx[k]), q);
      check_data("wb_dat_o ram", m_ram[work_idx[k]], q);
    end
    end_test("memory", errs);
  endtask

  task automatic test_io();
    soc_pkg::sel_t  s;
    soc_pkg::data_t d;
    soc_pkg::data_t q;
    int             errs;
    errs = fail_cnt;
    for (int n = 0; n < IO_OPS; n++) begin
      sw = soc_pkg::sw_t'($urandom);
      bus_read(1'b1, SW_ADR, q);
      check_data("wb_dat_o switches", soc_pkg::data_t'(sw), q);
      s = soc_pkg::sel_t'($urandom);
      d = soc_pkg::data_t'($urandom);
      bus_write(1'b1, LED_ADR, s, d);
      m_led = soc_pkg::led_t'(merge_lanes(soc_pkg::data_t'(m_led), d, s));
      check_led("led_o", m_led, led);
      bus_read(1'b1, LED_ADR, q);
      check_data("wb_dat_o leds", soc_pkg::data_t'(m_led), q);
      // Switch word is read-only
      bus_write(1'b1, SW_ADR, 2'b11, soc_pkg::data_t'($urandom));
      check_led("led_o after switch write", m_led, led);
    end
    end_test("io_port", errs);
  endtask

  task automatic test_unmapped();
    soc_pkg::addr_t a;
    soc_pkg::data_t q;
    int             k;
    int             errs;
    errs = fail_cnt;
    for (int n = 0; n < UNMAP_OPS; n++) begin
      // Upper bits set, low bits alias a live RAM word
      k = $urandom_range(0, WORK_WORDS - 1);
      a = soc_pkg::addr_t'(($urandom_range(1, 511) * RAM_WORDS) | work_idx[k]);
      bus_read(1'b0, a, q);
      check_data("wb_dat_o unmapped memory", 16'hFFFF, q);
      bus_write(1'b0, a, 2'b11, soc_pkg::data_t'($urandom));
      a = soc_pkg::addr_t'($urandom_range(0, 32'h7FFF));
      if (a == SW_ADR || a == LED_ADR) a = 19'h00100;
      bus_read(1'b1, a, q);
      check_data("wb_dat_o unmapped io", 16'hFFFF, q);
      bus_write(1'b1, a, 2'b11, soc_pkg::data_t'($urandom));
    end
    check_led("led_o after unmapped writes", m_led, led);
    for (int i = 0; i < WORK_WORDS; i++) begin
      bus_read(1'b0, soc_pkg::addr_t'(work_idx[i]), q);
      check_data("wb_dat_o ram after unmapped writes", m_ram[work_idx[i]], q);
    end
    end_test("unmapped", errs);
  endtask

  task automatic test_priority();
    soc_pkg::iid_t  exp_id;
    soc_pkg::data_t vec;
    int             acks;
    int             errs;
    errs = fail_cnt;
    for (int r = 0; r < PRIO_ROUNDS; r++) begin
      @(negedge clk);
      irq_lines = 7'($urandom_range(1, 127));
      @(negedge clk);
      irq_lines = '0;
      repeat (3) @(negedge clk);
      check_flag("intr_o", m_pend != 0, intr);
      acks = 0;
      // Lowest pending line is served first
      while (m_pend != 0 && acks < 9) begin
        exp_id = m_iid;
        check_iid("iid", exp_id, DUT.iid);
        int_ack(vec);
        check_data("wb_dat_o vector", 16'd8 + soc_pkg::data_t'(exp_id), vec);
        acks++;
      end
      if (m_pend != 0) report_error("pending lines did not drain after nine acknowledges");
      check_flag("intr_o after last acknowledge", 1'b0, intr);
    end
    end_test("priority", errs);
  endtask

  task automatic test_timer();
    soc_pkg::data_t vec;
    int             waited;
    int             errs;
    errs = fail_cnt;
    irq_lines = '0;
    for (int n = 0; n < 2; n++) begin
      waited = 0;
      while (!intr && waited < TIMER_PERIOD + 10) begin
        @(negedge clk);
        waited++;
      end
      if (!intr) report_error("timer interrupt did not arrive within one period");
      check_flag("intr_o timer", m_pend != 0, intr);
      repeat (2) @(negedge clk);
      check_iid("iid timer", m_iid, DUT.iid);
      int_ack(vec);
      check_data("wb_dat_o timer vector", 16'd8, vec);
      check_flag("intr_o after timer acknowledge", m_pend != 0, intr);
    end
    end_test("timer", errs);
  endtask

  initial begin : main
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_tga    = 1'b0;
    wb_adr    = '0;
    wb_sel    = '0;
    wb_wdat   = '0;
    sw        = '0;
    irq_lines = '0;
    inta      = 1'b0;
    pass_cnt  = 0;
    fail_cnt  = 0;
    m_led     = '0;
    void'($urandom(62492));
    @(posedge rst_lck);
    @(negedge clk);
    test_memory();
    test_io();
    test_unmapped();
    test_priority();
    test_timer();
    $display("checks passed %0d, failed %0d, assertion failures %0d",
             pass_cnt, fail_cnt, DUT.u_checker.fail_count);
    if (fail_cnt == 0 && DUT.u_checker.fail_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    #((WATCHDOG_CYCLES + 10) * CLK_PERIOD);
    $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== pc_bus_soc.f ====
soc_pkg.sv
soc_timer.sv
soc_pic.sv
soc_gpio.sv
soc_scratch_ram.sv
soc_bus_ctrl.sv
soc_top.sv
tb_soc_clk.sv
tb_soc_checker.sv
tb_soc.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the system bus testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_soc \
  -f pc_bus_soc.f -o sim_tb_soc
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb_soc +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Simulation finished: PASS"; then
  exit 0
fi
exit 1
